// ==== ma_wb_pipeline.f ====
+incdir+rtl
+incdir+tb
rtl/ma_pkg.sv
rtl/mawb_if.sv
rtl/branch_resolver.sv
rtl/reset_point_unit.sv
rtl/ma_stage.sv
rtl/wb_stage.sv
rtl/ma_wb_pipeline.sv
tb/tb_ma_wb_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MA/WB pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_ma_wb_pipeline \
    -f ma_wb_pipeline.f -o sim_tb

# The log decides the result, so a failing run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== tb/ma_wb_model.svh ====
`ifndef MA_WB_MODEL_SVH
`define MA_WB_MODEL_SVH

// Expected register-file write one cycle after accept
typedef struct packed {
    logic                we;
    rf_add_t             rd;
    logic [`MA_XLEN-1:0] val;
} wb_exp_t;

wb_exp_t             wb_q[$];                       // One entry per checked cycle
logic [`MA_XLEN-1:0] m_rst_point = `MA_BOOT_ADDR;   // PC of the instruction in MA
logic [`MA_XLEN-1:0] m_mepc = `MA_BOOT_ADDR;
logic [`MA_XLEN-1:0] m_next_pc;
logic [`MA_XLEN-1:0] m_new_rp;                      // Also the expected TOC address
logic                m_stall, m_accept, m_int, m_flush;
logic                m_bpu, m_jpu, m_btbu, m_btrue, m_bop_pop;
wb_exp_t             m_wb;
int                  n_accepted = 0;

// Pick the addressed byte or half out of the bus word and extend it
function automatic logic [`MA_XLEN-1:0] load_value(input ma_op_e op, input logic [1:0] off,
                                                   input logic [`MA_XLEN-1:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{off, 3'b000} +: 8];
    h = word[{off[1], 4'b0000} +: 16];      // Halves sit on even offsets
    case (op)
        OP_LB:   load_value = {{24{b[7]}}, b};
        OP_LBU:  load_value = {24'd0, b};
        OP_LH:   load_value = {{16{h[15]}}, h};
        OP_LHU:  load_value = {16'd0, h};
        default: load_value = word;         // Aligned word
    endcase
endfunction

// Expected outputs for the inputs now at the DUT
task automatic predict_outputs();
    logic load;
    logic lsu;
    logic ctrl;
    logic taken;
    logic miss_tgt;
    logic mret;
    load      = exma_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    lsu       = load | (exma_op == OP_SW);
    m_stall   = exma_valid & lsu & ~lsu_ready;  // Bus not ready holds the instruction
    m_accept  = exma_valid & ~m_stall;
    m_int     = m_accept & int_pending & ~lsu;  // LSU ops are never interrupted
    m_bpu     = m_accept & ~m_int & (exma_op == OP_BRANCH);
    m_jpu     = m_accept & ~m_int & (exma_op == OP_JUMP);
    mret      = m_accept & ~m_int & (exma_op == OP_MRET);
    ctrl      = m_bpu | m_jpu;
    taken     = (m_bpu & exma_cond) | m_jpu;
    // An invalid BOP entry holds no usable target
    miss_tgt  = exma_pred & (~bop_pred | (bop_tadd != exma_val[`MA_XLEN-1:1]));
    m_btrue   = m_bpu & exma_cond;
    m_btbu    = taken & (~exma_pred | miss_tgt);
    m_bop_pop = ctrl & exma_pred;
    m_flush   = m_int | mret | (ctrl & ((taken != exma_pred) | miss_tgt));
    m_next_pc = m_rst_point + (exma_rvc ? `MA_PC_INCR_RVC : `MA_PC_INCR_STD);
    if (m_int) m_new_rp = `MA_TRAP_VECTOR;
    else if (mret) m_new_rp = m_mepc;
    else if (taken) m_new_rp = exma_val;
    else m_new_rp = m_next_pc;
    m_wb.we = m_accept & ~m_int & (exma_rd != 5'd0) &
              !(exma_op inside {OP_SW, OP_BRANCH, OP_MRET});
    m_wb.rd = exma_rd;
    if (load) m_wb.val = load_value(exma_op, exma_val[1:0], lsu_data);
    else if (exma_op == OP_JUMP) m_wb.val = m_next_pc;     // Link address
    else m_wb.val = exma_val;
endtask

// State change at the edge that ends the cycle
task automatic retire_instr();
    wb_q.push_back(m_wb);
    if (m_accept) begin
        if (m_int) m_mepc = m_rst_point;    // Return to the interrupted instruction
        m_rst_point = m_new_rp;
        n_accepted++;
    end
endtask

`endif

// ==== tb/tb_ma_wb_pipeline.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module tb_ma_wb_pipeline import ma_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int N_INSTR    = 2000;
    localparam int TIMEOUT_NS = (N_INSTR * 4 + RST_CYCLES + 4) * CLK_PERIOD;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                exma_valid, exma_rvc, exma_cond, exma_pred;
    ma_op_e              exma_op;
    rf_add_t             exma_rd;
    logic [`MA_XLEN-1:0] exma_val;
    logic [`MA_XLEN-2:0] bop_tadd;
    logic                bop_pred, lsu_ready, int_pending;
    logic [`MA_XLEN-1:0] lsu_data;
    logic                stall, flush, int_ack, bpu, jpu, btbu, btrue, bop_pop;
    logic [`MA_XLEN-1:0] toc_addr;
    logic                rf_we;
    rf_add_t             rf_rd;
    logic [`MA_XLEN-1:0] rf_val;
    integer              seed = 32'h07bff237;
    // Op table with ALU and control flow weighted up
    ma_op_e op_mix [0:15] = '{OP_ALU, OP_ALU, OP_ALU, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
                              OP_SW, OP_BRANCH, OP_BRANCH, OP_JUMP, OP_JUMP, OP_MRET,
                              OP_ALU, OP_LW};

    `include "ma_wb_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    ma_wb_pipeline DUT (
        .s_clk_i (clk), .rst_n_i (rst_n),
        .s_exma_valid_i (exma_valid), .s_exma_op_i (exma_op), .s_exma_rd_i (exma_rd),
        .s_exma_val_i (exma_val), .s_exma_rvc_i (exma_rvc), .s_exma_cond_i (exma_cond),
        .s_exma_pred_i (exma_pred), .s_bop_tadd_i (bop_tadd), .s_bop_pred_i (bop_pred),
        .s_lsu_data_i (lsu_data), .s_lsu_ready_i (lsu_ready), .s_int_pending_i (int_pending),
        .s_stall_o (stall), .s_flush_o (flush), .s_toc_addr_o (toc_addr),
        .s_int_ack_o (int_ack), .s_bpu_o (bpu), .s_jpu_o (jpu), .s_btbu_o (btbu),
        .s_btrue_o (btrue), .s_bop_pop_o (bop_pop),
        .s_rf_we_o (rf_we), .s_rf_rd_o (rf_rd), .s_rf_val_o (rf_val)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_rd(input string name, input rf_add_t got, input rf_add_t exp);
        if (got !== exp) abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [`MA_XLEN-1:0] got,
                              input logic [`MA_XLEN-1:0] exp);
        if (got !== exp) abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Bus and interrupt change every cycle, the instruction only when not held
    task automatic drive_inputs(input logic hold);
        logic [31:0] r;
        logic [31:0] r2;
        r           = $random(seed);
        lsu_ready   = r[1:0] != 2'b00;      // Ready three cycles in four
        int_pending = r[7:4] == 4'd0;
        lsu_data    = $random(seed);
        if (!hold) begin
            r          = $random(seed);
            r2         = $random(seed);
            exma_valid = r[1:0] != 2'b00;
            exma_rvc   = r[2];
            exma_cond  = r[3];
            exma_pred  = r[4];
            bop_pred   = r[5];
            exma_rd    = r[12:8];
            exma_op    = op_mix[r[19:16]];
            exma_val   = $random(seed);
            bop_tadd   = r[6] ? exma_val[`MA_XLEN-1:1] : r2[30:0];  // Half the time a hit
            if (exma_op == OP_LW) exma_val[1:0] = 2'b00;
            if (exma_op inside {OP_LH, OP_LHU}) exma_val[0] = 1'b0;
        end
    endtask

    // Sampled at the falling edge away from input changes
    task automatic compare_cycle();
        wb_exp_t e;
        predict_outputs();
        check_flag("s_stall_o", stall, m_stall);
        check_flag("s_flush_o", flush, m_flush);
        check_flag("s_int_ack_o", int_ack, m_int);
        if (m_flush) check_word("s_toc_addr_o", toc_addr, m_new_rp);
        check_flag("s_bpu_o", bpu, m_bpu);
        check_flag("s_jpu_o", jpu, m_jpu);
        check_flag("s_btbu_o", btbu, m_btbu);
        check_flag("s_btrue_o", btrue, m_btrue);
        check_flag("s_bop_pop_o", bop_pop, m_bop_pop);
        e = wb_q.pop_front();               // Pushed one cycle ago
        check_flag("s_rf_we_o", rf_we, e.we);
        if (e.we) begin
            check_rd("s_rf_rd_o", rf_rd, e.rd);
            check_word("s_rf_val_o", rf_val, e.val);
        end
        retire_instr();
    endtask

    initial begin
        rst_n = 1'b0;
        drive_inputs(1'b0);
        exma_valid = 1'b0;
        wb_q.push_back('0);                 // Nothing in WB out of reset
        repeat (RST_CYCLES) begin
            @(negedge clk);
            compare_cycle();
        end
        while (n_accepted < N_INSTR) begin
            @(posedge clk);
            #1;
            rst_n = 1'b1;
            drive_inputs(m_stall);
            // First instruction is a plain ALU write
            if (n_accepted == 0) begin
                exma_valid  = 1'b1;
                exma_op     = OP_ALU;
                exma_rd     = exma_rd | 5'd1;
                int_pending = 1'b0;
            end
            @(negedge clk);
            compare_cycle();
        end
        @(posedge clk);
        #1;
        exma_valid = 1'b0;                  // Drain the last write-back
        @(negedge clk);
        compare_cycle();
        $display("all tests passed");
        $finish;
    end

    // At most four cycles per instruction plus reset
    initial begin
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before all instructions were accepted");
    end

endmodule

// ==== rtl/ma_wb_pipeline.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module ma_wb_pipeline import ma_pkg::*; (
    input  logic                s_clk_i,
    input  logic                rst_n_i,

    input  logic                s_exma_valid_i,     // EX/MA boundary
    input  ma_op_e              s_exma_op_i,
    input  rf_add_t             s_exma_rd_i,
    input  logic [`MA_XLEN-1:0] s_exma_val_i,
    input  logic                s_exma_rvc_i,
    input  logic                s_exma_cond_i,
    input  logic                s_exma_pred_i,

    input  logic [`MA_XLEN-2:0] s_bop_tadd_i,       // Branch predictor BOP
    input  logic                s_bop_pred_i,

    input  logic [`MA_XLEN-1:0] s_lsu_data_i,       // Data bus
    input  logic                s_lsu_ready_i,
    input  logic                s_int_pending_i,

    output logic                s_stall_o,          // Toward front end
    output logic                s_flush_o,
    output logic [`MA_XLEN-1:0] s_toc_addr_o,
    output logic                s_int_ack_o,

    output logic                s_bpu_o,            // Predictor strobes
    output logic                s_jpu_o,
    output logic                s_btbu_o,
    output logic                s_btrue_o,
    output logic                s_bop_pop_o,

    output logic                s_rf_we_o,          // Register-file write port
    output rf_add_t             s_rf_rd_o,
    output logic [`MA_XLEN-1:0] s_rf_val_o
);

    mawb_if #(.W($bits(mawb_t))) m_mawb ();

    ma_stage m_ma_stage (
        .s_clk_i         (s_clk_i),
        .rst_n_i         (rst_n_i),
        .s_exma_valid_i  (s_exma_valid_i),
        .s_exma_op_i     (s_exma_op_i),
        .s_exma_rd_i     (s_exma_rd_i),
        .s_exma_val_i    (s_exma_val_i),
        .s_exma_rvc_i    (s_exma_rvc_i),
        .s_exma_cond_i   (s_exma_cond_i),
        .s_exma_pred_i   (s_exma_pred_i),
        .s_bop_tadd_i    (s_bop_tadd_i),
        .s_bop_pred_i    (s_bop_pred_i),
        .s_lsu_data_i    (s_lsu_data_i),
        .s_lsu_ready_i   (s_lsu_ready_i),
        .s_int_pending_i (s_int_pending_i),
        .s_stall_o       (s_stall_o),
        .s_flush_o       (s_flush_o),
        .s_int_ack_o     (s_int_ack_o),
        .s_toc_addr_o    (s_toc_addr_o),
        .s_bpu_o         (s_bpu_o),
        .s_jpu_o         (s_jpu_o),
        .s_btbu_o        (s_btbu_o),
        .s_btrue_o       (s_btrue_o),
        .s_bop_pop_o     (s_bop_pop_o),
        .mawb            (m_mawb.ma_mp)
    );

    wb_stage m_wb_stage (
        .mawb       (m_mawb.wb_mp),
        .s_rf_we_o  (s_rf_we_o),
        .s_rf_rd_o  (s_rf_rd_o),
        .s_rf_val_o (s_rf_val_o)
    );

endmodule

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module wb_stage import ma_pkg::*; (
    mawb_if.wb_mp               mawb,           // MA/WB register

    output logic                s_rf_we_o,      // Register-file write port
    output rf_add_t             s_rf_rd_o,
    output logic [`MA_XLEN-1:0] s_rf_val_o
);

    mawb_t               s_mawb;
    logic [`MA_XLEN-1:0] s_word;
    logic [`MA_XLEN-1:0] s_shift;   // Addressed byte moved to bit 0
    logic [`MA_XLEN-1:0] s_rf_val;

    assign s_mawb  = mawb.data;
    assign s_word  = s_mawb.val;
    assign s_shift = s_word >> {s_mawb.ldi.addr, 3'b000};

    // Byte and half extension while other ops pass unchanged
    always_comb begin
        case (s_mawb.ldi.op)
            OP_LB: begin
                s_rf_val = {{24{s_shift[7]}}, s_shift[7:0]};
            end
            OP_LBU: begin
                s_rf_val = {24'd0, s_shift[7:0]};
            end
            OP_LH: begin
                s_rf_val = {{16{s_shift[15]}}, s_shift[15:0]};
            end
            OP_LHU: begin
                s_rf_val = {16'd0, s_shift[15:0]};
            end
            OP_LW: begin
                s_rf_val = s_shift;     // Offset zero for aligned words
            end
            default: begin
                s_rf_val = s_word;      // ALU result or link address
            end
        endcase
    end

    // Write only while WB holds an instruction
    assign s_rf_we_o  = mawb.valid & s_mawb.we;
    assign s_rf_rd_o  = s_mawb.rd;
    assign s_rf_val_o = s_rf_val;

endmodule

// ==== rtl/ma_stage.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module ma_stage import ma_pkg::*; (
    input  logic                s_clk_i,
    input  logic                rst_n_i,

    input  logic                s_exma_valid_i,     // One-cycle instruction strobe
    input  ma_op_e              s_exma_op_i,
    input  rf_add_t             s_exma_rd_i,
    input  logic [`MA_XLEN-1:0] s_exma_val_i,       // EX result, address or target
    input  logic                s_exma_rvc_i,
    input  logic                s_exma_cond_i,      // Branch condition
    input  logic                s_exma_pred_i,      // Predicted taken

    input  logic [`MA_XLEN-2:0] s_bop_tadd_i,
    input  logic                s_bop_pred_i,

    input  logic [`MA_XLEN-1:0] s_lsu_data_i,       // Raw bus read word
    input  logic                s_lsu_ready_i,
    input  logic                s_int_pending_i,

    output logic                s_stall_o,
    output logic                s_flush_o,
    output logic                s_int_ack_o,
    output logic [`MA_XLEN-1:0] s_toc_addr_o,
    output logic                s_bpu_o,
    output logic                s_jpu_o,
    output logic                s_btbu_o,
    output logic                s_btrue_o,
    output logic                s_bop_pop_o,

    mawb_if.ma_mp               mawb
);

    logic                s_is_load;
    logic                s_is_lsu;
    logic                s_stall;
    logic                s_accept;
    logic                s_interrupt;
    logic                s_mret;
    logic                s_active;
    logic                s_taken;
    logic                s_mispredict;
    logic [`MA_XLEN-1:0] s_next_pc;
    logic [`MA_XLEN-1:0] s_new_rst_point;
    mawb_t               s_wmawb;

    assign s_is_load = (s_exma_op_i == OP_LB)  | (s_exma_op_i == OP_LH) |
                       (s_exma_op_i == OP_LW)  | (s_exma_op_i == OP_LBU) |
                       (s_exma_op_i == OP_LHU);
    assign s_is_lsu  = s_is_load | (s_exma_op_i == OP_SW);

    assign s_stall     = s_exma_valid_i & s_is_lsu & ~s_lsu_ready_i;   // Bus transfer extended
    assign s_accept    = s_exma_valid_i & ~s_stall;
    assign s_interrupt = s_accept & s_int_pending_i & ~s_is_lsu;        // Wait for LSU to finish
    assign s_mret      = s_accept & ~s_interrupt & (s_exma_op_i == OP_MRET);
    assign s_active    = s_accept & ~s_interrupt;   // Interrupted op leaves no trace

    branch_resolver m_branch_resolver (
        .s_active_i     (s_active),
        .s_op_i         (s_exma_op_i),
        .s_cond_i       (s_exma_cond_i),
        .s_predicted_i  (s_exma_pred_i),
        .s_target_i     (s_exma_val_i),
        .s_bop_tadd_i   (s_bop_tadd_i),
        .s_bop_pred_i   (s_bop_pred_i),
        .s_taken_o      (s_taken),
        .s_mispredict_o (s_mispredict),
        .s_bpu_o        (s_bpu_o),
        .s_jpu_o        (s_jpu_o),
        .s_btbu_o       (s_btbu_o),
        .s_btrue_o      (s_btrue_o),
        .s_bop_pop_o    (s_bop_pop_o)
    );

    reset_point_unit m_reset_point_unit (
        .s_clk_i           (s_clk_i),
        .rst_n_i           (rst_n_i),
        .s_advance_i       (s_accept),
        .s_interrupt_i     (s_interrupt),
        .s_mret_i          (s_mret),
        .s_taken_i         (s_taken),
        .s_rvc_i           (s_exma_rvc_i),
        .s_target_i        (s_exma_val_i),
        .s_next_pc_o       (s_next_pc),
        .s_new_rst_point_o (s_new_rst_point)
    );

    // Front end restarts from the new reset point
    assign s_stall_o    = s_stall;
    assign s_flush_o    = s_interrupt | s_mret | s_mispredict;
    assign s_toc_addr_o = s_new_rst_point;
    assign s_int_ack_o  = s_interrupt;

    always_comb begin
        s_wmawb.rd       = s_exma_rd_i;
        s_wmawb.ldi.op   = s_exma_op_i;
        s_wmawb.ldi.addr = s_exma_val_i[1:0];   // Load address offset
        if (s_is_load) begin
            s_wmawb.val = s_lsu_data_i;         // Aligned in WB
        end else if (s_exma_op_i == OP_JUMP) begin
            s_wmawb.val = s_next_pc;            // Link address
        end else begin
            s_wmawb.val = s_exma_val_i;
        end
        // No register write for these
        s_wmawb.we = ~((s_exma_op_i == OP_SW) | (s_exma_op_i == OP_BRANCH) |
                       (s_exma_op_i == OP_MRET) | s_interrupt | (s_exma_rd_i == '0));
    end

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mawb.valid <= 1'b0;
        end else begin
            mawb.valid <= s_accept;     // One cycle in WB
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (s_accept) begin
            mawb.data <= s_wmawb;
        end
    end

endmodule

// ==== rtl/reset_point_unit.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module reset_point_unit import ma_pkg::*; (
    input  logic                s_clk_i,
    input  logic                rst_n_i,
    input  logic                s_advance_i,        // Instruction accepted in MA
    input  logic                s_interrupt_i,      // Interrupt taken on this instruction
    input  logic                s_mret_i,           // Trap return executed
    input  logic                s_taken_i,          // Branch or jump taken
    input  logic                s_rvc_i,            // Compressed instruction
    input  logic [`MA_XLEN-1:0] s_target_i,         // Branch or jump target

    output logic [`MA_XLEN-1:0] s_next_pc_o,        // Sequential successor
    output logic [`MA_XLEN-1:0] s_new_rst_point_o   // Reset point after this instruction
);

    logic [`MA_XLEN-1:0] s_rst_point;   // PC of the instruction in MA
    logic [`MA_XLEN-1:0] s_mepc;        // Exception PC
    logic [`MA_XLEN-1:0] s_pc_incr;
    logic [`MA_XLEN-1:0] s_next_pc;
    logic [`MA_XLEN-1:0] s_new_rst_point;

    // 2 for RVC, 4 otherwise
    assign s_pc_incr = s_rvc_i ? `MA_XLEN'(`MA_PC_INCR_RVC) : `MA_XLEN'(`MA_PC_INCR_STD);
    assign s_next_pc = s_rst_point + s_pc_incr;

    // Interrupt first, then trap return, taken transfer and fall-through
    always_comb begin
        if (s_interrupt_i) begin
            s_new_rst_point = `MA_TRAP_VECTOR;
        end else if (s_mret_i) begin
            s_new_rst_point = s_mepc;       // Resume interrupted code
        end else if (s_taken_i) begin
            s_new_rst_point = s_target_i;
        end else begin
            s_new_rst_point = s_next_pc;
        end
    end

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s_rst_point <= `MA_BOOT_ADDR;
            s_mepc      <= `MA_BOOT_ADDR;
        end else if (s_advance_i) begin
            s_rst_point <= s_new_rst_point;
            // Interrupted instruction never executed, so return to it
            if (s_interrupt_i) begin
                s_mepc <= s_rst_point;
            end
        end
    end

    assign s_next_pc_o       = s_next_pc;
    assign s_new_rst_point_o = s_new_rst_point;

endmodule

// ==== rtl/branch_resolver.sv ====
`timescale 1ns/1ps
`include "ma_macros.svh"

module branch_resolver import ma_pkg::*; (
    input  logic                s_active_i,     // Instruction accepted, not interrupted
    input  ma_op_e              s_op_i,         // MA operation
    input  logic                s_cond_i,       // Branch condition from EX
    input  logic                s_predicted_i,  // Front end predicted taken
    input  logic [`MA_XLEN-1:0] s_target_i,     // Computed target address
    input  logic [`MA_XLEN-2:0] s_bop_tadd_i,   // Predicted target held in the BOP
    input  logic                s_bop_pred_i,   // BOP entry is valid

    output logic                s_taken_o,      // Control transfer really happens
    output logic                s_mispredict_o, // Front end went the wrong way
    output logic                s_bpu_o,        // Branch predictor update
    output logic                s_jpu_o,        // Jump predictor update
    output logic                s_btbu_o,       // BTB update
    output logic                s_btrue_o,      // Branch outcome
    output logic                s_bop_pop_o     // Retire oldest BOP entry
);

    logic s_branch;
    logic s_jump;
    logic s_ctrl;
    logic s_taken;
    logic s_mistarget;

    assign s_branch = s_active_i & (s_op_i == OP_BRANCH);
    assign s_jump   = s_active_i & (s_op_i == OP_JUMP);
    assign s_ctrl   = s_branch | s_jump;    // Any branch or jump in MA

    // Jumps always go, branches only on condition
    assign s_taken  = (s_branch & s_cond_i) | s_jump;

    // Predicted taken but the stored target is missing or wrong
    // Bit 0 of the target is never stored in the BOP
    assign s_mistarget = s_predicted_i &
                         (~s_bop_pred_i | (s_bop_tadd_i != s_target_i[`MA_XLEN-1:1]));

    // Direction disagreement or bad target
    assign s_mispredict_o = s_ctrl & ((s_taken != s_predicted_i) | s_mistarget);

    assign s_taken_o   = s_taken;
    assign s_bpu_o     = s_branch;                                  // Every branch trains
    assign s_jpu_o     = s_jump;                                    // Every jump trains
    assign s_btbu_o    = s_taken & (~s_predicted_i | s_mistarget);  // New or fixed BTB entry
    assign s_btrue_o   = s_branch & s_cond_i;
    assign s_bop_pop_o = s_ctrl & s_predicted_i;                    // Entry was pushed in fetch

endmodule

// ==== rtl/mawb_if.sv ====
`timescale 1ns/1ps

// MA/WB pipeline register contents seen by both stages
interface mawb_if #(
    parameter int W = 44    // Packed width of the MA/WB payload
);

    logic [W-1:0] data;     // Payload, written on accept
    logic         valid;    // Instruction present in WB

    // Register side in the MA stage
    modport ma_mp (
        output data,
        output valid
    );

    // Consumer side
    modport wb_mp (
        input data,
        input valid
    );

endinterface

// ==== rtl/ma_pkg.sv ====
`include "ma_macros.svh"

package ma_pkg;

    // Operation of the instruction entering MA
    typedef enum logic [`MA_OP_W-1:0] {
        OP_NONE   = 4'd0,   // Bubble
        OP_ALU    = 4'd1,   // Result already computed in EX
        OP_LB     = 4'd2,
        OP_LH     = 4'd3,
        OP_LW     = 4'd4,
        OP_LBU    = 4'd5,
        OP_LHU    = 4'd6,
        OP_SW     = 4'd7,   // Store without register write
        OP_BRANCH = 4'd8,   // Conditional branch
        OP_JUMP   = 4'd9,   // Jump and link
        OP_MRET   = 4'd10   // Trap return
    } ma_op_e;

    // Register-file address
    typedef logic [4:0] rf_add_t;

    // Info the WB stage needs to decode loaded data
    typedef struct packed {
        ma_op_e     op;     // Load width and sign
        logic [1:0] addr;   // Byte offset within the word
    } ld_info_t;

    // Content of the MA/WB pipeline register
    typedef struct packed {
        logic                 we;    // Register-file write enable
        rf_add_t              rd;    // Destination register
        logic [`MA_XLEN-1:0]  val;   // Result or raw loaded word
        ld_info_t             ldi;   // Load decode info
    } mawb_t;

endpackage

// ==== rtl/ma_macros.svh ====
`ifndef MA_MACROS_SVH
`define MA_MACROS_SVH

// Data path and address width
`define MA_XLEN 32

// Reset point loaded after reset
`define MA_BOOT_ADDR 32'h0000_0200

// Fixed interrupt entry address
`define MA_TRAP_VECTOR 32'h0000_0100

// Next-PC step for compressed and standard instructions
`define MA_PC_INCR_RVC 2
`define MA_PC_INCR_STD 4

// Width of the MA operation code
`define MA_OP_W 4

`endif
